//--- gomoku_settings.svh
// board geometry, score width and pattern weights for the gomoku scorer
`ifndef GOMOKU_SETTINGS_SVH
`define GOMOKU_SETTINGS_SVH

// board and window geometry
`define GOMOKU_BOARD_DIM 15
`define GOMOKU_WIN_LEN 5
`define GOMOKU_NUM_DIRS 4

// signed score width
`define GOMOKU_SCORE_W 32

// five-cell pattern weights
`define GOMOKU_W_FIVE 1000000
`define GOMOKU_W_THREE 1000
`define GOMOKU_W_TWO 100
`define GOMOKU_W_BLOCKED_FOUR 10000
`define GOMOKU_W_BLOCKED_THREE 100
`define GOMOKU_W_BLOCKED_TWO 10

`endif

//--- gomoku_pkg.sv
// cell, board, window, score record and pattern types plus the pattern table
`include "gomoku_settings.svh"

package gomoku_pkg;

    // code 3 is unused and matches nothing
    typedef enum logic [1:0] {
        cell_black = 2'd0,
        cell_white = 2'd1,
        cell_empty = 2'd2
    } cell_t;

    // cell (r, c) at index r*15+c
    typedef cell_t [`GOMOKU_BOARD_DIM*`GOMOKU_BOARD_DIM-1:0] board_t;

    // cells[0] is the anchor, code is the raw compare word
    typedef union packed {
        cell_t [`GOMOKU_WIN_LEN-1:0] cells;
        logic [2*`GOMOKU_WIN_LEN-1:0] code;
    } window_u;

    typedef struct packed {
        logic [`GOMOKU_NUM_DIRS-1:0] valid;
        logic last;
        window_u [`GOMOKU_NUM_DIRS-1:0] win;
    } dir_frame_t;

    typedef struct packed {
        logic signed [`GOMOKU_SCORE_W-1:0] black;
        logic signed [`GOMOKU_SCORE_W-1:0] white;
    } side_score_t;

    typedef struct packed {
        logic last;
        side_score_t score;
    } scored_t;

    // colour 0 is black, 1 is white
    typedef struct packed {
        window_u win;
        logic colour;
        logic signed [`GOMOKU_SCORE_W-1:0] weight;
    } pattern_t;

    // bit k of stones marks a stone at cell k from the anchor
    function automatic pattern_t mk_pattern(input logic colour, input logic [4:0] stones,
                                            input int weight);
        pattern_t p;
        for (int k = 0; k < `GOMOKU_WIN_LEN; k++) begin
            p.win.cells[k] = stones[k] ? (colour ? cell_white : cell_black) : cell_empty;
        end
        p.colour = colour;
        p.weight = weight;
        return p;
    endfunction

    localparam pattern_t gomoku_patterns [0:19] = '{
        mk_pattern(1'b0, 5'b11111, `GOMOKU_W_FIVE),
        mk_pattern(1'b0, 5'b01110, `GOMOKU_W_THREE),
        mk_pattern(1'b0, 5'b01010, `GOMOKU_W_TWO),
        mk_pattern(1'b0, 5'b11101, `GOMOKU_W_BLOCKED_FOUR),
        mk_pattern(1'b0, 5'b10111, `GOMOKU_W_BLOCKED_FOUR),
        mk_pattern(1'b0, 5'b11011, `GOMOKU_W_BLOCKED_FOUR),
        mk_pattern(1'b0, 5'b11001, `GOMOKU_W_BLOCKED_THREE),
        mk_pattern(1'b0, 5'b10011, `GOMOKU_W_BLOCKED_THREE),
        mk_pattern(1'b0, 5'b10101, `GOMOKU_W_BLOCKED_THREE),
        mk_pattern(1'b0, 5'b10001, `GOMOKU_W_BLOCKED_TWO),
        mk_pattern(1'b1, 5'b11111, `GOMOKU_W_FIVE),
        mk_pattern(1'b1, 5'b01110, `GOMOKU_W_THREE),
        mk_pattern(1'b1, 5'b01010, `GOMOKU_W_TWO),
        mk_pattern(1'b1, 5'b11101, `GOMOKU_W_BLOCKED_FOUR),
        mk_pattern(1'b1, 5'b10111, `GOMOKU_W_BLOCKED_FOUR),
        mk_pattern(1'b1, 5'b11011, `GOMOKU_W_BLOCKED_FOUR),
        mk_pattern(1'b1, 5'b11001, `GOMOKU_W_BLOCKED_THREE),
        mk_pattern(1'b1, 5'b10011, `GOMOKU_W_BLOCKED_THREE),
        mk_pattern(1'b1, 5'b10101, `GOMOKU_W_BLOCKED_THREE),
        mk_pattern(1'b1, 5'b10001, `GOMOKU_W_BLOCKED_TWO)
    };

endpackage

//--- window_feeder.sv
// board walker emitting the four direction windows of each anchor
`timescale 1ns/1ps
`include "gomoku_settings.svh"

module window_feeder (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_start,
    input  gomoku_pkg::board_t     i_board,
    output gomoku_pkg::dir_frame_t o_frame
);

    localparam int dim = `GOMOKU_BOARD_DIM;
    localparam int win_len = `GOMOKU_WIN_LEN;
    localparam int ndirs = `GOMOKU_NUM_DIRS;
    localparam int cnt_w = $clog2(dim);

    logic busy_q;
    logic [cnt_w-1:0] row_q;
    logic [cnt_w-1:0] col_q;
    logic at_end;

    logic [ndirs-1:0] valid_d;
    logic [ndirs-1:0] valid_q;
    logic last_d;
    logic last_q;
    gomoku_pkg::window_u [ndirs-1:0] win_d;
    gomoku_pkg::window_u [ndirs-1:0] win_q;

    // off-board cells read as empty, the valid bit drops those windows anyway
    function automatic gomoku_pkg::cell_t cell_at(input gomoku_pkg::board_t b,
                                                  input int r, input int c);
        if (r < 0 || r >= dim || c < 0 || c >= dim) begin
            return gomoku_pkg::cell_empty;
        end
        return b[r*dim+c];
    endfunction

    assign at_end = (row_q == dim - 1) && (col_q == dim - 1);

    // row-major walk over all anchors
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            busy_q <= 1'b0;
            row_q <= '0;
            col_q <= '0;
        end else if (!busy_q) begin
            if (i_start) begin
                busy_q <= 1'b1;
                row_q <= '0;
                col_q <= '0;
            end
        end else if (at_end) begin
            busy_q <= 1'b0;
        end else if (col_q == dim - 1) begin
            col_q <= '0;
            row_q <= row_q + 1'b1;
        end else begin
            col_q <= col_q + 1'b1;
        end
    end

    always_comb begin
        for (int k = 0; k < win_len; k++) begin
            win_d[0].cells[k] = cell_at(i_board, int'(row_q), int'(col_q) + k);
            win_d[1].cells[k] = cell_at(i_board, int'(row_q) + k, int'(col_q));
            win_d[2].cells[k] = cell_at(i_board, int'(row_q) + k, int'(col_q) + k);
            win_d[3].cells[k] = cell_at(i_board, int'(row_q) + k, int'(col_q) - k);
        end
        // whole window on the board
        valid_d[0] = busy_q && (col_q <= dim - win_len);
        valid_d[1] = busy_q && (row_q <= dim - win_len);
        valid_d[2] = busy_q && (row_q <= dim - win_len) && (col_q <= dim - win_len);
        valid_d[3] = busy_q && (row_q <= dim - win_len) && (col_q >= win_len - 1);
        last_d = busy_q && at_end;
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            valid_q <= '0;
            last_q <= 1'b0;
        end else begin
            valid_q <= valid_d;
            last_q <= last_d;
        end
    end

    always_ff @(posedge i_clk) begin
        win_q <= win_d;
    end

    always_comb begin
        o_frame.valid = valid_q;
        o_frame.last = last_q;
        o_frame.win = win_q;
    end

endmodule

//--- window_scorer.sv
// one direction scorer matching a window against the pattern table
`timescale 1ns/1ps
`include "gomoku_settings.svh"

module window_scorer (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  gomoku_pkg::window_u   i_window,
    input  logic                  i_valid,
    input  logic                  i_last,
    output gomoku_pkg::scored_t   o_scored
);

    logic signed [`GOMOKU_SCORE_W-1:0] black_d;
    logic signed [`GOMOKU_SCORE_W-1:0] white_d;
    logic signed [`GOMOKU_SCORE_W-1:0] black_q;
    logic signed [`GOMOKU_SCORE_W-1:0] white_q;
    logic last_q;

    // codes are all distinct so at most one entry hits
    always_comb begin
        black_d = '0;
        white_d = '0;
        for (int p = 0; p < $size(gomoku_pkg::gomoku_patterns); p++) begin
            if (i_valid && i_window.code == gomoku_pkg::gomoku_patterns[p].win.code) begin
                if (gomoku_pkg::gomoku_patterns[p].colour) begin
                    white_d = gomoku_pkg::gomoku_patterns[p].weight;
                end else begin
                    black_d = gomoku_pkg::gomoku_patterns[p].weight;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            black_q <= '0;
            white_q <= '0;
            last_q <= 1'b0;
        end else begin
            black_q <= black_d;
            white_q <= white_d;
            last_q <= i_last;
        end
    end

    always_comb begin
        o_scored.last = last_q;
        o_scored.score.black = black_q;
        o_scored.score.white = white_q;
    end

endmodule

//--- score_accumulator.sv
// running black and white totals, turn-relative final score and finish pulse
`timescale 1ns/1ps
`include "gomoku_settings.svh"

module score_accumulator (
    input  logic                                               i_clk,
    input  logic                                               i_rst_n,
    input  gomoku_pkg::scored_t [`GOMOKU_NUM_DIRS-1:0]         i_scored,
    input  logic                                               i_turn,
    output logic signed [`GOMOKU_SCORE_W-1:0]                  o_score,
    output logic                                               o_finish
);

    logic signed [`GOMOKU_SCORE_W-1:0] black_sum;
    logic signed [`GOMOKU_SCORE_W-1:0] white_sum;
    logic any_last;

    logic signed [`GOMOKU_SCORE_W-1:0] black_tot_q;
    logic signed [`GOMOKU_SCORE_W-1:0] white_tot_q;
    logic last_q;
    logic signed [`GOMOKU_SCORE_W-1:0] score_q;
    logic finish_q;

    always_comb begin
        black_sum = '0;
        white_sum = '0;
        any_last = 1'b0;
        for (int d = 0; d < `GOMOKU_NUM_DIRS; d++) begin
            black_sum = black_sum + i_scored[d].score.black;
            white_sum = white_sum + i_scored[d].score.white;
            any_last = any_last | i_scored[d].last;
        end
    end

    // totals restart from the current records once the last one has gone in
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            black_tot_q <= '0;
            white_tot_q <= '0;
            last_q <= 1'b0;
            score_q <= '0;
            finish_q <= 1'b0;
        end else begin
            black_tot_q <= (last_q ? '0 : black_tot_q) + black_sum;
            white_tot_q <= (last_q ? '0 : white_tot_q) + white_sum;
            last_q <= any_last;
            finish_q <= last_q;
            if (last_q) begin
                score_q <= i_turn ? (white_tot_q - black_tot_q) : (black_tot_q - white_tot_q);
            end
        end
    end

    assign o_score = score_q;
    assign o_finish = finish_q;

endmodule

//--- board_scorer.sv
// top level with the board walker, per-direction scorers and the accumulator
`timescale 1ns/1ps
`include "gomoku_settings.svh"

module board_scorer (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              i_start,
    input  gomoku_pkg::board_t                i_board,
    input  logic                              i_turn,
    output logic signed [`GOMOKU_SCORE_W-1:0] o_score,
    output logic                              o_finish
);

    gomoku_pkg::dir_frame_t frame;
    gomoku_pkg::scored_t [`GOMOKU_NUM_DIRS-1:0] scored;

    window_feeder u_window_feeder (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (i_start),
        .i_board (i_board),
        .o_frame (frame)
    );

    // 0 horizontal, 1 vertical, 2 diagonal, 3 anti-diagonal
    for (genvar d = 0; d < `GOMOKU_NUM_DIRS; d++) begin : g_dir
        window_scorer u_window_scorer (
            .i_clk    (i_clk),
            .i_rst_n  (i_rst_n),
            .i_window (frame.win[d]),
            .i_valid  (frame.valid[d]),
            .i_last   (frame.last),
            .o_scored (scored[d])
        );
    end

    score_accumulator u_score_accumulator (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_scored (scored),
        .i_turn   (i_turn),
        .o_score  (o_score),
        .o_finish (o_finish)
    );

endmodule

//--- tb_score_model.svh
// reference scoring model, board building helpers and the LFSR for the testbench
`ifndef TB_SCORE_MODEL_SVH
`define TB_SCORE_MODEL_SVH

`include "gomoku_settings.svh"

logic [15:0] lfsr_state = 16'd80;

// fibonacci taps 16 14 13 11, one step per bit taken
function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
endfunction

function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
        v = (v << 1) | int'(lfsr_bit());
    end
    return v;
endfunction

// bit k of the mask is the stone k steps from the anchor
function automatic int mask_weight(input logic [4:0] mask);
    case (mask)
        5'b11111: return `GOMOKU_W_FIVE;
        5'b01110: return `GOMOKU_W_THREE;
        5'b01010: return `GOMOKU_W_TWO;
        5'b11101, 5'b10111, 5'b11011: return `GOMOKU_W_BLOCKED_FOUR;
        5'b11001, 5'b10011, 5'b10101: return `GOMOKU_W_BLOCKED_THREE;
        5'b10001: return `GOMOKU_W_BLOCKED_TWO;
        default: return 0;
    endcase
endfunction

function automatic int model_score(input gomoku_pkg::board_t b, input logic turn);
    int dr [4] = '{0, 1, 1, 1};
    int dc [4] = '{1, 0, 1, -1};
    int dim;
    int total;
    int r;
    int c;
    logic [1:0] v;
    logic [4:0] mask_b;
    logic [4:0] mask_w;
    logic clash_b;
    logic clash_w;
    dim = `GOMOKU_BOARD_DIM;
    total = 0;
    for (int a = 0; a < dim * dim; a++) begin
        for (int d = 0; d < 4; d++) begin
            r = a / dim;
            c = a % dim;
            // far end of the window must stay on the board
            if (r + 4 * dr[d] < dim && c + 4 * dc[d] >= 0 && c + 4 * dc[d] < dim) begin
                mask_b = '0;
                mask_w = '0;
                clash_b = 1'b0;
                clash_w = 1'b0;
                for (int k = 0; k < 5; k++) begin
                    v = b[(r + k * dr[d]) * dim + c + k * dc[d]];
                    if (v == 2'd0) begin
                        mask_b[k] = 1'b1;
                        clash_w = 1'b1;
                    end else if (v == 2'd1) begin
                        mask_w[k] = 1'b1;
                        clash_b = 1'b1;
                    end else if (v != 2'd2) begin
                        clash_b = 1'b1;
                        clash_w = 1'b1;
                    end
                end
                if (!clash_b) total = total + mask_weight(mask_b);
                if (!clash_w) total = total - mask_weight(mask_w);
            end
        end
    end
    return turn ? -total : total;
endfunction

function automatic gomoku_pkg::board_t empty_board();
    gomoku_pkg::board_t b;
    for (int i = 0; i < `GOMOKU_BOARD_DIM * `GOMOKU_BOARD_DIM; i++) begin
        b[i] = gomoku_pkg::cell_empty;
    end
    return b;
endfunction

function automatic gomoku_pkg::board_t put_stone(input gomoku_pkg::board_t b, input int r,
                                                 input int c, input logic colour);
    b[r * `GOMOKU_BOARD_DIM + c] = colour ? gomoku_pkg::cell_white : gomoku_pkg::cell_black;
    return b;
endfunction

// stones land on free cells only
function automatic gomoku_pkg::board_t random_board(input int count);
    gomoku_pkg::board_t b;
    int pos;
    b = empty_board();
    for (int n = 0; n < count; n++) begin
        pos = rand_bits(8);
        while (pos >= `GOMOKU_BOARD_DIM * `GOMOKU_BOARD_DIM || b[pos] != gomoku_pkg::cell_empty) begin
            pos = rand_bits(8);
        end
        b = put_stone(b, pos / `GOMOKU_BOARD_DIM, pos % `GOMOKU_BOARD_DIM, lfsr_bit());
    end
    return b;
endfunction

`endif

//--- tb_board_scorer.sv
// testbench top with clock, reset, stimulus table, score check and finish timeouts
`timescale 1ns/1ps
`include "gomoku_settings.svh"

module tb_board_scorer;

    typedef struct packed {
        logic used;
        logic [3:0] row;
        logic [3:0] col;
        logic colour;
    } stone_t;

    typedef struct packed {
        stone_t [5:0] stones;
        logic [6:0] n_random;
        logic turn;
        logic from_model;
        logic [31:0] expected;
    } case_t;

    localparam stone_t nos = '0;
    localparam int finish_timeout = 400;

    logic i_clk;
    logic i_rst_n;
    logic i_start;
    gomoku_pkg::board_t i_board;
    logic i_turn;
    logic signed [`GOMOKU_SCORE_W-1:0] o_score;
    logic o_finish;

    case_t cases [$];
    case_t cur;
    gomoku_pkg::board_t board;
    int finishes;

    `include "tb_score_model.svh"

    board_scorer u_board_scorer (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_start  (i_start),
        .i_board  (i_board),
        .i_turn   (i_turn),
        .o_score  (o_score),
        .o_finish (o_finish)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    function automatic stone_t st(input int r, input int c, input int colour);
        return {1'b1, 4'(r), 4'(c), 1'(colour)};
    endfunction

    function automatic void add_case(input stone_t [5:0] s, input int n_random, input int turn,
                                     input logic from_model, input logic [31:0] expected);
        case_t e;
        e.stones = s;
        e.n_random = 7'(n_random);
        e.turn = 1'(turn);
        e.from_model = from_model;
        e.expected = expected;
        cases.push_back(e);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    // one walk from the start pulse to the finish pulse
    task automatic score_walk(input gomoku_pkg::board_t b, input logic turn,
                              input logic [31:0] expected);
        int cycles;
        @(posedge i_clk);
        #2;
        i_board = b;
        i_turn = turn;
        i_start = 1'b1;
        @(posedge i_clk);
        #2;
        i_start = 1'b0;
        cycles = 0;
        while (o_finish !== 1'b1) begin
            if (cycles >= finish_timeout) begin
                abort_run("The scorer gave no finish pulse within 400 cycles of the start.");
            end
            @(posedge i_clk);
            #2;
            cycles++;
        end
        check_value("finish_latency", cycles, 228);
        check_value("o_score", o_score, expected);
        @(posedge i_clk);
        #2;
        check_value("o_finish", o_finish, 1'b0);
        check_value("o_score", o_score, expected);
    endtask

    initial begin
        i_rst_n = 1'b0;
        i_start = 1'b0;
        i_turn = 1'b0;
        i_board = empty_board();
        repeat (16) begin
            @(posedge i_clk);
            #2;
            check_value("o_finish", o_finish, 1'b0);
        end
        i_rst_n = 1'b1;
        check_value("o_score", o_score, 32'h0);

        // stones, random count, turn, from model, literal score
        add_case('0, 0, 0, 1'b0, 0);
        add_case('0, 0, 1, 1'b0, 0);
        add_case({st(7, 7, 0), nos, nos, nos, nos, nos}, 0, 0, 1'b0, 0);
        add_case({st(7, 7, 0), nos, nos, nos, nos, nos}, 0, 1, 1'b0, 0);
        add_case({st(0, 0, 1), nos, nos, nos, nos, nos}, 0, 0, 1'b0, 0);
        add_case({st(0, 0, 1), nos, nos, nos, nos, nos}, 0, 1, 1'b0, 0);
        add_case({st(7, 3, 0), st(7, 4, 0), st(7, 5, 0), st(7, 6, 0), st(7, 7, 0), nos},
                 0, 0, 1'b0, 1000000);
        add_case({st(7, 3, 0), st(7, 4, 0), st(7, 5, 0), st(7, 6, 0), st(7, 7, 0), nos},
                 0, 1, 1'b0, -1000000);
        add_case({st(5, 6, 1), st(6, 6, 1), st(7, 6, 1), nos, nos, nos}, 0, 0, 1'b1, 0);
        add_case({st(3, 3, 0), st(4, 4, 0), st(5, 5, 0), st(7, 7, 0), nos, nos}, 0, 0, 1'b1, 0);
        add_case({st(3, 10, 0), st(5, 8, 0), st(7, 6, 0), nos, nos, nos}, 0, 0, 1'b1, 0);
        add_case({st(10, 4, 1), st(10, 6, 1), nos, nos, nos, nos}, 0, 0, 1'b1, 0);
        // edge and corner lines
        add_case({st(0, 0, 0), st(0, 1, 0), st(0, 2, 0), st(0, 3, 0), st(0, 4, 0), nos},
                 0, 0, 1'b1, 0);
        add_case({st(10, 14, 1), st(11, 14, 1), st(12, 14, 1), st(13, 14, 1), st(14, 14, 1),
                  nos}, 0, 0, 1'b1, 0);
        add_case({st(0, 14, 0), st(1, 13, 0), st(2, 12, 0), st(3, 11, 0), st(4, 10, 0), nos},
                 0, 0, 1'b1, 0);
        // an open three if the window ran off the right edge
        add_case({st(7, 12, 0), st(7, 13, 0), st(7, 14, 0), nos, nos, nos}, 0, 0, 1'b0, 0);
        add_case('0, 20, 0, 1'b1, 0);
        add_case('0, 28, 0, 1'b1, 0);
        add_case('0, 36, 0, 1'b1, 0);
        add_case('0, 44, 0, 1'b1, 0);
        add_case('0, 52, 0, 1'b1, 0);
        add_case('0, 60, 0, 1'b1, 0);

        foreach (cases[i]) begin
            cur = cases[i];
            board = (cur.n_random != 0) ? random_board(cur.n_random) : empty_board();
            for (int s = 0; s < 6; s++) begin
                if (cur.stones[s].used) begin
                    board = put_stone(board, cur.stones[s].row, cur.stones[s].col,
                                      cur.stones[s].colour);
                end
            end
            if (cur.from_model) begin
                score_walk(board, 1'b0, model_score(board, 1'b0));
                score_walk(board, 1'b1, model_score(board, 1'b1));
            end else begin
                score_walk(board, cur.turn, cur.expected);
            end
        end

        // restart pulse in the middle of a walk
        board = random_board(40);
        @(posedge i_clk);
        #2;
        i_board = board;
        i_turn = 1'b1;
        i_start = 1'b1;
        @(posedge i_clk);
        #2;
        i_start = 1'b0;
        repeat (50) @(posedge i_clk);
        #2;
        i_start = 1'b1;
        @(posedge i_clk);
        #2;
        i_start = 1'b0;
        finishes = 0;
        for (int n = 0; n < 500; n++) begin
            @(posedge i_clk);
            #2;
            if (o_finish === 1'b1) finishes++;
        end
        check_value("finish_count", finishes, 1);
        check_value("o_score", o_score, model_score(board, 1'b1));

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- src.f
+incdir+.
gomoku_pkg.sv
window_feeder.sv
window_scorer.sv
score_accumulator.sv
board_scorer.sv
tb_board_scorer.sv

//--- Bender.yml
package:
  name: gomoku_board_scorer

export_include_dirs:
  - .

sources:
  - gomoku_pkg.sv
  - window_feeder.sv
  - window_scorer.sv
  - score_accumulator.sv
  - board_scorer.sv
  - target: test
    files:
      - tb_board_scorer.sv
